//--- verif/pru_fetch_cases.txt
# order (0 ascending, 1 descending)  sbu bitmap in hex, bit n is sbu n
# expected count-read total, four rows per set sbu
0 0000 0
1 0000 0
0 FFFF 64
1 FFFF 64
0 0001 4
1 0001 4
0 8000 4
1 8000 4
0 A5A5 32
1 A5A5 32
0 1234 20
1 1234 20
0 0F0F 32
1 F0F0 32
0 8001 8
1 8001 8
0 7FFE 56
1 7FFE 56
0 0010 4
1 0400 4
0 C003 16
1 3C3C 32
0 DEAD 44
1 BEEF 52
0 0100 4
1 FFFE 60

//--- verilog.f
source/sort_geom_pkg.sv
source/pru_ctrl_pkg.sv
source/scan_cnt_if.sv
source/pru_scan_cnt.sv
source/pru_fifo_room.sv
source/pru_scan_fsm.sv
source/pru_fetch_top.sv
verif/tb_pru_fetch.sv

//--- Makefile
TOP = tb_pru_fetch

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_pru_fetch.sv
`timescale 1ns/100ps

module tb_pru_fetch;

    localparam int PREFETCH_DEPTH = 16;
    localparam int SBU_NUM        = sort_geom_pkg::SBU_NUM;
    localparam int ROWS_PER_SBU   = sort_geom_pkg::ROWS_PER_SBU;
    localparam int BK_NUM         = sort_geom_pkg::BK_NUM;

    localparam sort_geom_pkg::sbu_addr_t SBU_TOP = sort_geom_pkg::sbu_addr_t'(SBU_NUM - 1);
    localparam sort_geom_pkg::row_addr_t ROW_TOP = sort_geom_pkg::row_addr_t'(ROWS_PER_SBU - 1);

    logic                       clk;
    logic                       arst_n;
    logic                       start;
    logic                       order;
    logic                       sbu_rd_vld;
    logic                       sbu_rd_data;
    logic                       cnt_rd_1f_vld;
    logic                       cnt_rd_vld;
    sort_geom_pkg::fifo_level_t fifo_level;
    logic                       sbu_req_vld;
    sort_geom_pkg::sbu_addr_t   sbu_req_addr;
    logic                       cnt_req_vld;
    sort_geom_pkg::cnt_addr_t   cnt_req_addr;
    logic                       done;

    // cases from the data file
    logic                       case_order[$];
    logic [SBU_NUM-1:0]         case_map[$];
    int                         case_reads[$];

    logic                       cur_order;
    logic [SBU_NUM-1:0]         cur_map;
    sort_geom_pkg::sbu_addr_t   exp_sbu;
    sort_geom_pkg::sbu_addr_t   end_sbu;
    sort_geom_pkg::cnt_addr_t   end_addr;
    sort_geom_pkg::cnt_addr_t   exp_addr[$];
    sort_geom_pkg::cnt_addr_t   popped;
    int                         read_cnt;
    int                         done_cnt;
    int                         sbu_req_cnt;
    logic                       last_read;
    logic                       exp_done;

    // model state
    integer                     seed;
    int                         sbu_wait;
    logic                       sbu_answered;
    sort_geom_pkg::sbu_addr_t   sbu_pend_addr;
    logic                       sbu_vld_nxt;
    logic                       sbu_data_nxt;
    logic                       rd1_nxt;
    logic                       rd2_nxt;
    int                         fifo_lvl;
    int                         fifo_lvl_nxt;
    int                         cycles;
    int                         cycle_limit;

    pru_fetch_top #(
        .PREFETCH_DEPTH (PREFETCH_DEPTH)
    ) i_dut (
        .clk_i               (clk),
        .arst_n_i            (arst_n),
        .start_i             (start),
        .order_i             (order),
        .sbu2pru_rd_vld_i    (sbu_rd_vld),
        .sbu2pru_rd_data_i   (sbu_rd_data),
        .cnt2pru_rd_1f_vld_i (cnt_rd_1f_vld),
        .cnt2pru_rd_vld_i    (cnt_rd_vld),
        .fifo_level_i        (fifo_level),
        .pru2sbu_rd_vld_o    (sbu_req_vld),
        .pru2sbu_rd_addr_o   (sbu_req_addr),
        .pru2cnt_rd_vld_o    (cnt_req_vld),
        .pru2cnt_rd_addr_o   (cnt_req_addr),
        .pru_done_o          (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_cnt_addr(input sort_geom_pkg::cnt_addr_t act,
                                  input sort_geom_pkg::cnt_addr_t exp);
        if (act !== exp) begin
            $display("** Error at %0t: count read address %0h, expected %0h", $time, act, exp);
            stop_run();
        end
    endtask

    task automatic check_sbu_addr(input sort_geom_pkg::sbu_addr_t act,
                                  input sort_geom_pkg::sbu_addr_t exp);
        if (act !== exp) begin
            $display("** Error at %0t: sbu request address %0d, expected %0d", $time, act, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string what, input int act, input int exp);
        if (act != exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, act, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string what, input logic act, input logic exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, what, act, exp);
            stop_run();
        end
    endtask

    // lines starting with # are skipped
    task automatic load_cases();
        int                 fd;
        int                 rc;
        int                 n;
        int                 o;
        int                 reads;
        logic [SBU_NUM-1:0] map;
        string              line;
        fd = $fopen("verif/pru_fetch_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file verif/pru_fetch_cases.txt");
            stop_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %d", o, map, reads);
                    if (n == 3) begin
                        case_order.push_back(o != 0);
                        case_map.push_back(map);
                        case_reads.push_back(reads);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // rows of every set sbu in scan order
    function automatic void build_expected(input logic desc, input logic [SBU_NUM-1:0] map);
        int i;
        int j;
        int s;
        int r;
        exp_addr.delete();
        for (i = 0; i < SBU_NUM; i++) begin
            s = desc ? (SBU_NUM - 1 - i) : i;
            if (map[s]) begin
                for (j = 0; j < ROWS_PER_SBU; j++) begin
                    r = desc ? (ROWS_PER_SBU - 1 - j) : j;
                    exp_addr.push_back({sort_geom_pkg::sbu_addr_t'(s),
                                        sort_geom_pkg::row_addr_t'(r)});
                end
            end
        end
    endfunction

    task automatic run_case(input int idx);
        cur_order = case_order[idx];
        cur_map   = case_map[idx];
        build_expected(cur_order, cur_map);
        end_sbu     = cur_order ? '0 : SBU_TOP;
        end_addr    = cur_order ? '0 : {SBU_TOP, ROW_TOP};
        read_cnt    = 0;
        done_cnt    = 0;
        sbu_req_cnt = 0;
        @(posedge clk);
        #1;
        order = cur_order;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        // second strobe lands mid scan
        repeat (3) @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (done_cnt == 0) @(posedge clk);
        repeat (4) @(posedge clk);
        check_count("count reads", read_cnt, case_reads[idx]);
        check_count("sbu requests", sbu_req_cnt, SBU_NUM);
        check_count("count reads left", exp_addr.size(), 0);
    endtask

    // sample at the falling edge
    always @(negedge clk) begin
        if (!arst_n) begin
            sbu_wait     = 0;
            sbu_answered = 1'b0;
            sbu_vld_nxt  = 1'b0;
            sbu_data_nxt = 1'b0;
            rd1_nxt      = 1'b0;
            rd2_nxt      = 1'b0;
            fifo_lvl_nxt = 0;
        end else begin
            sbu_vld_nxt  = 1'b0;
            sbu_data_nxt = 1'b0;
            if (!sbu_req_vld) begin
                sbu_answered = 1'b0;
            end
            // one answer per presented address after 1 to 3 cycles
            if (sbu_wait == 0 && sbu_req_vld &&
                !(sbu_answered && sbu_req_addr == sbu_pend_addr)) begin
                if (sbu_req_cnt >= SBU_NUM) begin
                    $display("sbu request at %0t after the last sbu of the scan", $time);
                    stop_run();
                end else begin
                    exp_sbu = sort_geom_pkg::sbu_addr_t'(cur_order ? (SBU_NUM - 1 - sbu_req_cnt)
                                                                   : sbu_req_cnt);
                    check_sbu_addr(sbu_req_addr, exp_sbu);
                end
                sbu_req_cnt   = sbu_req_cnt + 1;
                sbu_pend_addr = sbu_req_addr;
                sbu_answered  = 1'b1;
                sbu_wait      = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
            end
            if (sbu_wait > 0) begin
                sbu_wait = sbu_wait - 1;
                if (sbu_wait == 0) begin
                    sbu_vld_nxt  = 1'b1;
                    sbu_data_nxt = cur_map[sbu_pend_addr];
                end
            end

            last_read = 1'b0;
            if (cnt_req_vld) begin
                if (exp_addr.size() == 0) begin
                    $display("count read at %0t when no read was left in this case", $time);
                    stop_run();
                end else begin
                    popped = exp_addr.pop_front();
                    check_cnt_addr(cnt_req_addr, popped);
                    read_cnt  = read_cnt + 1;
                    last_read = (popped == end_addr);
                end
            end

            // scan ends on an empty last sbu or its final row read
            exp_done = (sbu_rd_vld && !sbu_rd_data && sbu_pend_addr == end_sbu) || last_read;
            check_flag("done", done, exp_done);
            if (done) begin
                done_cnt = done_cnt + 1;
            end

            // two-stage count memory feeding the prefetch fifo
            rd1_nxt      = cnt_req_vld;
            rd2_nxt      = cnt_rd_1f_vld;
            fifo_lvl_nxt = fifo_lvl + (cnt_rd_vld ? BK_NUM : 0);
            if (fifo_lvl > 0 && ($random(seed) & 3) != 0) begin
                fifo_lvl_nxt = fifo_lvl_nxt - 1;
            end
            if (fifo_lvl_nxt > PREFETCH_DEPTH) begin
                $display("** Error at %0t: fifo level %0d above depth %0d",
                         $time, fifo_lvl_nxt, PREFETCH_DEPTH);
                stop_run();
            end
        end
    end

    always @(posedge clk) begin
        #1;
        sbu_rd_vld    = sbu_vld_nxt;
        sbu_rd_data   = sbu_data_nxt;
        cnt_rd_1f_vld = rd1_nxt;
        cnt_rd_vld    = rd2_nxt;
        fifo_lvl      = fifo_lvl_nxt;
        fifo_level    = sort_geom_pkg::fifo_level_t'(fifo_lvl);
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles without finishing all cases", cycle_limit);
            stop_run();
        end
    end

    initial begin
        int k;
        arst_n        = 1'b0;
        start         = 1'b0;
        order         = 1'b0;
        sbu_rd_vld    = 1'b0;
        sbu_rd_data   = 1'b0;
        cnt_rd_1f_vld = 1'b0;
        cnt_rd_vld    = 1'b0;
        fifo_level    = '0;
        fifo_lvl      = 0;
        fifo_lvl_nxt  = 0;
        sbu_vld_nxt   = 1'b0;
        sbu_data_nxt  = 1'b0;
        rd1_nxt       = 1'b0;
        rd2_nxt       = 1'b0;
        cur_order     = 1'b0;
        cur_map       = '0;
        seed          = 35059;
        cycles        = 0;
        cycle_limit   = 0;

        load_cases();
        cycle_limit = case_order.size() * (SBU_NUM * 4 + 16 * ROWS_PER_SBU * 8);

        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // nothing moves without a start
        repeat (6) begin
            @(negedge clk);
            check_flag("sbu request after reset", sbu_req_vld, 1'b0);
            check_flag("count read after reset", cnt_req_vld, 1'b0);
            check_flag("done after reset", done, 1'b0);
        end

        for (k = 0; k < case_order.size(); k++) begin
            run_case(k);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- source/pru_fetch_top.sv
`timescale 1ns/100ps

module pru_fetch_top #(
    parameter int PREFETCH_DEPTH = 16
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       start_i,
    input  logic                       order_i,
    input  logic                       sbu2pru_rd_vld_i,
    input  logic                       sbu2pru_rd_data_i,
    input  logic                       cnt2pru_rd_1f_vld_i,
    input  logic                       cnt2pru_rd_vld_i,
    input  sort_geom_pkg::fifo_level_t fifo_level_i,
    output logic                       pru2sbu_rd_vld_o,
    output sort_geom_pkg::sbu_addr_t   pru2sbu_rd_addr_o,
    output logic                       pru2cnt_rd_vld_o,
    output sort_geom_pkg::cnt_addr_t   pru2cnt_rd_addr_o,
    output logic                       pru_done_o
);

    pru_ctrl_pkg::scan_order_t scan_order;
    logic                      room_ok;

    // 1 selects descending scan
    assign scan_order = pru_ctrl_pkg::scan_order_t'(order_i);

    scan_cnt_if i_cnt_if ();

    pru_scan_cnt i_scan_cnt (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .order_i  (scan_order),
        .cnt      (i_cnt_if.cnt)
    );

    pru_fifo_room #(
        .PREFETCH_DEPTH (PREFETCH_DEPTH)
    ) i_fifo_room (
        .fifo_level_i    (fifo_level_i),
        .cnt_rd_1f_vld_i (cnt2pru_rd_1f_vld_i),
        .cnt_rd_vld_i    (cnt2pru_rd_vld_i),
        .room_ok_o       (room_ok)
    );

    pru_scan_fsm i_scan_fsm (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .start_i       (start_i),
        .sbu_rd_vld_i  (sbu2pru_rd_vld_i),
        .sbu_rd_data_i (sbu2pru_rd_data_i),
        .room_ok_i     (room_ok),
        .cnt           (i_cnt_if.seq),
        .sbu_rd_vld_o  (pru2sbu_rd_vld_o),
        .sbu_rd_addr_o (pru2sbu_rd_addr_o),
        .cnt_rd_vld_o  (pru2cnt_rd_vld_o),
        .cnt_rd_addr_o (pru2cnt_rd_addr_o),
        .done_o        (pru_done_o)
    );

endmodule

//--- source/pru_scan_fsm.sv
`timescale 1ns/100ps

module pru_scan_fsm (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      start_i,
    input  logic                      sbu_rd_vld_i,
    input  logic                      sbu_rd_data_i,
    input  logic                      room_ok_i,
    scan_cnt_if.seq                   cnt,
    output logic                      sbu_rd_vld_o,
    output sort_geom_pkg::sbu_addr_t  sbu_rd_addr_o,
    output logic                      cnt_rd_vld_o,
    output sort_geom_pkg::cnt_addr_t  cnt_rd_addr_o,
    output logic                      done_o
);

    pru_ctrl_pkg::pru_state_t state_q;
    pru_ctrl_pkg::pru_state_t state_d;

    logic in_idle;
    logic in_new_sbu;
    logic in_cnt_mem;
    logic sbu_hit;
    logic sbu_miss;
    logic rd_fire;
    logic sbu_done;

    assign in_idle    = (state_q == pru_ctrl_pkg::ST_IDLE);
    assign in_new_sbu = (state_q == pru_ctrl_pkg::ST_NEW_SBU);
    assign in_cnt_mem = (state_q == pru_ctrl_pkg::ST_CNT_MEM);

    // flag response for the current sbu
    assign sbu_hit  = in_new_sbu & sbu_rd_vld_i & sbu_rd_data_i;
    assign sbu_miss = in_new_sbu & sbu_rd_vld_i & ~sbu_rd_data_i;

    // one count read per cycle with room
    assign rd_fire  = in_cnt_mem & room_ok_i;

    // current sbu finished by empty flag or by its last row
    assign sbu_done = sbu_miss | (rd_fire & cnt.row_last);

    always_comb begin
        state_d = state_q;
        case (state_q)
            pru_ctrl_pkg::ST_IDLE: begin
                if (start_i) begin
                    state_d = pru_ctrl_pkg::ST_NEW_SBU;
                end
            end
            pru_ctrl_pkg::ST_NEW_SBU: begin
                if (sbu_hit) begin
                    state_d = pru_ctrl_pkg::ST_CNT_MEM;
                end else if (sbu_miss && cnt.sbu_last) begin
                    state_d = pru_ctrl_pkg::ST_IDLE;
                end
            end
            pru_ctrl_pkg::ST_CNT_MEM: begin
                if (rd_fire && cnt.row_last) begin
                    state_d = cnt.sbu_last ? pru_ctrl_pkg::ST_IDLE
                                           : pru_ctrl_pkg::ST_NEW_SBU;
                end
            end
            default: begin
                state_d = pru_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= pru_ctrl_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // counters sit at the first position while idle
    assign cnt.load     = in_idle;
    assign cnt.step_row = rd_fire & ~cnt.row_last;
    assign cnt.step_sbu = sbu_done & ~cnt.sbu_last;

    assign sbu_rd_vld_o  = in_new_sbu;
    assign sbu_rd_addr_o = cnt.sbu_cnt;

    assign cnt_rd_vld_o  = rd_fire;
    assign cnt_rd_addr_o = {cnt.sbu_cnt, cnt.row_cnt};

    // final transition back to idle
    assign done_o = sbu_done & cnt.sbu_last;

endmodule

//--- source/pru_fifo_room.sv
`timescale 1ns/100ps

module pru_fifo_room #(
    parameter int PREFETCH_DEPTH = 16
) (
    input  sort_geom_pkg::fifo_level_t fifo_level_i,
    input  logic                       cnt_rd_1f_vld_i,
    input  logic                       cnt_rd_vld_i,
    output logic                       room_ok_o
);

    logic [1:0] inflight;
    int         need;
    int         level;

    // reads still inside the count memory
    assign inflight = {1'b0, cnt_rd_1f_vld_i} + {1'b0, cnt_rd_vld_i};

    always_comb begin
        // entries claimed by in-flight reads plus the new one
        need  = (int'(inflight) + 1) * sort_geom_pkg::BK_NUM;
        level = int'(fifo_level_i);

        // depth smaller than the claim can never take it
        room_ok_o = (PREFETCH_DEPTH >= need) && (level <= PREFETCH_DEPTH - need);
    end

endmodule

//--- source/pru_scan_cnt.sv
`timescale 1ns/100ps

module pru_scan_cnt (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  pru_ctrl_pkg::scan_order_t order_i,
    scan_cnt_if.cnt                   cnt
);

    localparam sort_geom_pkg::sbu_addr_t SBU_MAX =
        sort_geom_pkg::sbu_addr_t'(sort_geom_pkg::SBU_NUM - 1);
    localparam sort_geom_pkg::row_addr_t ROW_MAX =
        sort_geom_pkg::row_addr_t'(sort_geom_pkg::ROWS_PER_SBU - 1);
    localparam sort_geom_pkg::sbu_addr_t SBU_ONE = sort_geom_pkg::sbu_addr_t'(1);
    localparam sort_geom_pkg::row_addr_t ROW_ONE = sort_geom_pkg::row_addr_t'(1);

    logic                     desc;
    sort_geom_pkg::sbu_addr_t sbu_first;
    sort_geom_pkg::sbu_addr_t sbu_end;
    sort_geom_pkg::sbu_addr_t sbu_nxt;
    sort_geom_pkg::sbu_addr_t sbu_q;
    sort_geom_pkg::row_addr_t row_first;
    sort_geom_pkg::row_addr_t row_end;
    sort_geom_pkg::row_addr_t row_nxt;
    sort_geom_pkg::row_addr_t row_q;

    assign desc = (order_i == pru_ctrl_pkg::ORDER_DESC);

    // first and last positions swap with the order
    assign sbu_first = desc ? SBU_MAX : '0;
    assign sbu_end   = desc ? '0 : SBU_MAX;
    assign row_first = desc ? ROW_MAX : '0;
    assign row_end   = desc ? '0 : ROW_MAX;

    assign sbu_nxt = desc ? (sbu_q - SBU_ONE) : (sbu_q + SBU_ONE);
    assign row_nxt = desc ? (row_q - ROW_ONE) : (row_q + ROW_ONE);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sbu_q <= '0;
        end else if (cnt.load) begin
            sbu_q <= sbu_first;
        end else if (cnt.step_sbu) begin
            sbu_q <= sbu_nxt;
        end
    end

    // a new sbu always starts at its first row
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            row_q <= '0;
        end else if (cnt.load || cnt.step_sbu) begin
            row_q <= row_first;
        end else if (cnt.step_row) begin
            row_q <= row_nxt;
        end
    end

    assign cnt.sbu_cnt  = sbu_q;
    assign cnt.row_cnt  = row_q;
    assign cnt.sbu_last = (sbu_q == sbu_end);
    assign cnt.row_last = (row_q == row_end);

endmodule

//--- source/scan_cnt_if.sv
`timescale 1ns/100ps

interface scan_cnt_if;

    logic                      load;
    logic                      step_sbu;
    logic                      step_row;
    sort_geom_pkg::sbu_addr_t  sbu_cnt;
    sort_geom_pkg::row_addr_t  row_cnt;
    logic                      sbu_last;
    logic                      row_last;

    // sequencer side
    modport seq (
        output load, step_sbu, step_row,
        input  sbu_cnt, row_cnt, sbu_last, row_last
    );

    // counter side
    modport cnt (
        input  load, step_sbu, step_row,
        output sbu_cnt, row_cnt, sbu_last, row_last
    );

endinterface

//--- source/pru_ctrl_pkg.sv
package pru_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_NEW_SBU = 2'd1,
        ST_CNT_MEM = 2'd2
    } pru_state_t;

    // descending starts from the top sbu and top row
    typedef enum logic {
        ORDER_ASC  = 1'b0,
        ORDER_DESC = 1'b1
    } scan_order_t;

endpackage

//--- source/sort_geom_pkg.sv
package sort_geom_pkg;

    // one count-memory row spans this many banks
    localparam int BK_NUM             = 4;
    localparam int SBU_NUM            = 16;
    localparam int ROWS_PER_SBU       = 4;
    localparam int MAX_PREFETCH_DEPTH = 31;

    localparam int SBU_ADDR_W   = $clog2(SBU_NUM);
    localparam int ROW_ADDR_W   = $clog2(ROWS_PER_SBU);
    localparam int CNT_ADDR_W   = SBU_ADDR_W + ROW_ADDR_W;
    // level may reach the full depth
    localparam int FIFO_LEVEL_W = $clog2(MAX_PREFETCH_DEPTH + 1);

    typedef logic [SBU_ADDR_W-1:0]   sbu_addr_t;
    typedef logic [ROW_ADDR_W-1:0]   row_addr_t;
    // sbu index on top, row below
    typedef logic [CNT_ADDR_W-1:0]   cnt_addr_t;
    typedef logic [FIFO_LEVEL_W-1:0] fifo_level_t;

endpackage
